//--- common/video_consts.svh
/* frame geometry of the reduced test raster
   palette depth, ulaplus base and index width */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// horizontal, in clocks per line
`define H_TOTAL        32
`define H_PIX_START    8
`define H_PIX_END      24
`define H_BLANK_START  28
`define H_BLANK_END    0   // wraps through end of line
`define H_SYNC_START   29
`define H_SYNC_END     31
`define H_BITS         5

// vertical, in lines per frame
`define V_TOTAL        20
`define V_PIX_START    4
`define V_PIX_END      14
`define V_BLANK_START  17
`define V_BLANK_END    0   // wraps through end of frame
`define V_SYNC_START   18
`define V_SYNC_END     19
`define V_BITS         5

// palette memory
`define PAL_DEPTH      512
`define PAL_UP_BASE    256 // upper half belongs to ulaplus
`define PAL_IDX_BITS   9

`endif

//--- common/video_pkg.sv
/* raster flag, picture input and video output structs */
package video_pkg;

	// registered raster flags for one position
	typedef struct packed
	{
		logic hpix;        // inside horizontal picture window
		logic vpix;        // inside vertical picture window
		logic hblank;
		logic vblank;
		logic hsync_start; // single clock at start of hsync
		logic hsync;
		logic vsync;
	} raster_t;

	// picture data for one clock, from the fetch side
	typedef struct packed
	{
		logic [3:0] pixels;    // classic pixel colour index
		logic [3:0] border;    // classic border colour index
		logic [1:0] up_palsel; // ulaplus palette group
		logic [2:0] up_paper;
		logic [2:0] up_ink;
		logic       up_pixel;  // ink when set, paper when clear
	} pix_in_t;

	// one clock of video output
	typedef struct packed
	{
		logic [5:0] color; // green 2, red 2, blue 2
		logic       hsync;
		logic       vsync;
		logic       blank;
	} vid_out_t;

endpackage

//--- common/palette_pkg.sv
/* palette write source opcode and palette write struct */
package palette_pkg;

	// which format the write data comes in
	typedef enum logic
	{
		PAL_SRC_ATM     = 1'b0, // six-bit classic, address from zxcolor
		PAL_SRC_ULAPLUS = 1'b1  // eight-bit entry, explicit address
	} pal_src_e;

	// single cycle palette write strobe, no ready
	typedef struct packed
	{
		logic       valid;
		pal_src_e   src;
		logic [5:0] addr; // ulaplus entry within upper half
		logic [7:0] data; // atm uses bits 5..0
	} pal_wr_t;

endpackage

//--- logic/raster_timing.sv
/* horizontal and vertical counters for the test frame
   and the registered raster flags derived from them */
`include "video_consts.svh"

module raster_timing (
	input  logic               clk,
	input  logic               reset,
	output video_pkg::raster_t raster
);
	logic [`H_BITS-1:0] h_cnt; // position shown on raster
	logic [`V_BITS-1:0] v_cnt;
	logic [`H_BITS-1:0] h_nxt;
	logic [`V_BITS-1:0] v_nxt;

	// half-open window, wraps when start is past end
	function automatic logic in_win(input int pos, input int first, input int last);
		if (first <= last)
			return (pos >= first) && (pos < last);
		else
			return (pos >= first) || (pos < last);
	endfunction

	// all flags for one position
	function automatic video_pkg::raster_t flags_of(input int h, input int v);
		video_pkg::raster_t f;
		f.hpix        = in_win(h, `H_PIX_START, `H_PIX_END);
		f.vpix        = in_win(v, `V_PIX_START, `V_PIX_END);
		f.hblank      = in_win(h, `H_BLANK_START, `H_BLANK_END);
		f.vblank      = in_win(v, `V_BLANK_START, `V_BLANK_END);
		f.hsync_start = (h == `H_SYNC_START);
		f.hsync       = in_win(h, `H_SYNC_START, `H_SYNC_END);
		f.vsync       = in_win(v, `V_SYNC_START, `V_SYNC_END);
		return f;
	endfunction

	always_comb
	begin
		h_nxt = h_cnt + 1'b1;
		v_nxt = v_cnt;
		if (h_cnt == `H_BITS'(`H_TOTAL - 1)) // end of line
		begin
			h_nxt = '0;
			if (v_cnt == `V_BITS'(`V_TOTAL - 1))
				v_nxt = '0; // end of frame
			else
				v_nxt = v_cnt + 1'b1;
		end
	end

	// flags registered from next position so they line up with the counters
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			h_cnt  <= '0;
			v_cnt  <= '0;
			raster <= flags_of(0, 0);
		end
		else
		begin
			h_cnt  <= h_nxt;
			v_cnt  <= v_nxt;
			raster <= flags_of(int'(h_nxt), int'(v_nxt));
		end
	end

endmodule

//--- palframe/palette_ram.sv
/* palette memory, one write port and one read-first registered read port */
`include "video_consts.svh"

module palette_ram #(
	parameter int DEPTH = `PAL_DEPTH,
	parameter int AW    = $clog2(DEPTH)
) (
	input  logic          clk,
	input  logic          we,
	input  logic [AW-1:0] waddr,
	input  logic [7:0]    wdata,
	input  logic [AW-1:0] raddr,
	output logic [7:0]    rdata
);
	// green 7..5, red 4..2, blue 1..0
	logic [7:0] mem [DEPTH];

	// write and read on the same edge
	// read returns the old entry on an address clash
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // old contents on a clash
	end

endmodule

//--- palframe/color_dither.sv
/* dither phase from pixel, line and frame counters
   and 3-to-2-bit reduction of red and green */
module color_dither (
	input  logic       clk,
	input  logic       reset,
	input  logic       hsync_start,
	input  logic       vsync,
	input  logic [2:0] green_in,
	input  logic [2:0] red_in,
	output logic [1:0] green_out,
	output logic [1:0] red_out
);
	logic [1:0] ctr;     // free-running pixel phase
	logic       line_f;  // toggles every line
	logic       frame_f; // toggles every frame
	logic       vsync_r;
	logic       vsync_rise;
	logic       plus1;

	// odd components sit halfway, plus1 picks the upper value
	function automatic logic [1:0] reduce(input logic [2:0] c, input logic up);
		case (c)
			3'd0:    return 2'd0;
			3'd1:    return up ? 2'd1 : 2'd0;
			3'd2:    return 2'd1;
			3'd3:    return up ? 2'd2 : 2'd1;
			3'd4:    return 2'd2;
			3'd5:    return up ? 2'd3 : 2'd2;
			default: return 2'd3; // 6 and 7 saturate
		endcase
	endfunction

	assign vsync_rise = vsync & ~vsync_r;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ctr     <= '0;
			line_f  <= 1'b0;
			frame_f <= 1'b0;
			vsync_r <= 1'b0;
		end
		else
		begin
			ctr     <= ctr + 1'b1;
			vsync_r <= vsync;
			if (hsync_start)
				line_f <= ~line_f;
			if (vsync_rise)
				frame_f <= ~frame_f;
		end
	end

	// half step alternates every 2 clocks, flips per line and per frame
	assign plus1 = ctr[1] ^ line_f ^ frame_f;

	assign green_out = reduce(green_in, plus1);
	assign red_out   = reduce(red_in, plus1);

endmodule

//--- palframe/palette_frame.sv
/* border and pixel mixing, palette index and write formatting
   palette lookup, dither, blanking and output registers */
`include "video_consts.svh"

module palette_frame (
	input  logic                 clk,
	input  logic                 reset,
	input  video_pkg::raster_t   raster,
	input  video_pkg::pix_in_t   pix_in,
	input  logic                 up_ena,
	input  palette_pkg::pal_wr_t pal_wr,
	output video_pkg::vid_out_t  vid_out,
	output logic [5:0]           palcolor // raw entry for readback
);
	localparam logic [`PAL_IDX_BITS-1:0] UP_BASE = `PAL_UP_BASE;

	logic                     in_pic;  // both windows open
	logic [3:0]               zxcolor; // classic index
	logic [5:0]               up_sel;  // index within ulaplus half
	logic [`PAL_IDX_BITS-1:0] rd_idx;
	logic [`PAL_IDX_BITS-1:0] wr_idx;
	logic [7:0]               wr_data;
	logic [7:0]               entry;   // stage 1, from palette ram
	logic [1:0]               grn;
	logic [1:0]               red;
	logic                     st1_vld; // entry came from a non-reset cycle
	logic                     st1_blank;
	logic                     st1_hsync;
	logic                     st1_vsync;

	assign in_pic  = raster.hpix & raster.vpix;
	assign zxcolor = in_pic ? pix_in.pixels : pix_in.border;

	// ulaplus index from group, paper/ink half, then ink or paper colour
	assign up_sel = in_pic ?
		{pix_in.up_palsel, ~pix_in.up_pixel,
		 pix_in.up_pixel ? pix_in.up_ink : pix_in.up_paper} :
		{3'd0, pix_in.border[2:0]}; // border reads the first eight entries

	assign rd_idx = up_ena ? UP_BASE + `PAL_IDX_BITS'(up_sel) : `PAL_IDX_BITS'(zxcolor);

	// write address and entry format by source
	always_comb
	begin
		if (pal_wr.src == palette_pkg::PAL_SRC_ATM)
		begin
			wr_idx  = `PAL_IDX_BITS'(zxcolor); // colour under the beam
			wr_data = {pal_wr.data[3:2], 1'b0, pal_wr.data[5:4], 1'b0, pal_wr.data[1:0]};
		end
		else
		begin
			wr_idx  = UP_BASE + `PAL_IDX_BITS'(pal_wr.addr);
			wr_data = pal_wr.data; // already g3 r3 b2
		end
	end

	palette_ram #(
		.DEPTH (`PAL_DEPTH)
	) palette_ram_inst (
		.clk   (clk),
		.we    (pal_wr.valid),
		.waddr (wr_idx),
		.wdata (wr_data),
		.raddr (rd_idx),
		.rdata (entry)
	);

	color_dither color_dither_inst (
		.clk         (clk),
		.reset       (reset),
		.hsync_start (raster.hsync_start),
		.vsync       (raster.vsync),
		.green_in    (entry[7:5]),
		.red_in      (entry[4:2]),
		.green_out   (grn),
		.red_out     (red)
	);

	// flags delayed alongside the ram read
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			st1_vld   <= 1'b0;
			st1_blank <= 1'b1;
			st1_hsync <= 1'b0;
			st1_vsync <= 1'b0;
		end
		else
		begin
			st1_vld   <= 1'b1;
			st1_blank <= raster.hblank | raster.vblank;
			st1_hsync <= raster.hsync;
			st1_vsync <= raster.vsync;
		end
	end

	// output stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vid_out  <= '{color: '0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
			palcolor <= '0;
		end
		else
		begin
			vid_out.color <= st1_blank ? 6'd0 : {grn, red, entry[1:0]};
			vid_out.hsync <= st1_hsync;
			vid_out.vsync <= st1_vsync;
			vid_out.blank <= st1_blank;
			if (st1_vld)
				palcolor <= {entry[4:3], entry[7:6], entry[1:0]}; // r2 g2 b2
		end
	end

endmodule

//--- logic/video_top.sv
/* colour output stage top, raster timing plus palette frame */
module video_top (
	input  logic                 clk,
	input  logic                 reset,
	input  video_pkg::pix_in_t   pix_in,   // picture for current position
	input  palette_pkg::pal_wr_t pal_wr,   // palette write strobe
	input  logic                 up_ena,   // ulaplus mode
	output video_pkg::vid_out_t  vid_out,
	output logic [5:0]           palcolor
);
	video_pkg::raster_t raster; // position flags, registered

	raster_timing raster_timing_inst (
		.clk    (clk),
		.reset  (reset),
		.raster (raster)
	);

	// 2 clock latency from pix_in to vid_out
	palette_frame palette_frame_inst (
		.clk      (clk),
		.reset    (reset),
		.raster   (raster),
		.pix_in   (pix_in),
		.up_ena   (up_ena),
		.pal_wr   (pal_wr),
		.vid_out  (vid_out),
		.palcolor (palcolor)
	);

endmodule

//--- verification/video_ref_model.svh
/* testbench raster model, shadow palette and reference colour
   lfsr stimulus source and value compare */
`ifndef VIDEO_REF_MODEL_SVH
`define VIDEO_REF_MODEL_SVH

// expected outputs for one position
typedef struct packed
{
	logic                valid;
	logic                chk_color; // entry known, or blanked anyway
	logic                chk_pal;   // entry known
	video_pkg::vid_out_t vo;
	logic [5:0]          pc;
} expect_t;

logic [7:0]  shadow [`PAL_DEPTH]; // mirror of palette ram
bit          known [`PAL_DEPTH];  // set once an entry is written
logic [15:0] lfsr = 16'd46;

function automatic video_pkg::raster_t raster_model(input int h, input int v);
	video_pkg::raster_t r;
	r.hpix        = (h >= `H_PIX_START) && (h < `H_PIX_END);
	r.vpix        = (v >= `V_PIX_START) && (v < `V_PIX_END);
	r.hblank      = (h >= `H_BLANK_START); // runs to end of line
	r.vblank      = (v >= `V_BLANK_START); // runs to end of frame
	r.hsync_start = (h == `H_SYNC_START);
	r.hsync       = (h >= `H_SYNC_START) && (h < `H_SYNC_END);
	r.vsync       = (v >= `V_SYNC_START) && (v < `V_SYNC_END);
	return r;
endfunction

// 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] bits;
	logic        fb;
	bits = '0;
	for (int i = 0; i < n; i++)
	begin
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		bits = {bits[30:0], fb};
	end
	return bits;
endfunction

function automatic int zx_index(input video_pkg::raster_t r, input video_pkg::pix_in_t p);
	return (r.hpix && r.vpix) ? p.pixels : p.border;
endfunction

function automatic int read_index(input video_pkg::raster_t r, input video_pkg::pix_in_t p,
		input logic up);
	if (!up)
		return zx_index(r, p);
	if (r.hpix && r.vpix) // paper entries sit 8 above ink
		return `PAL_UP_BASE + p.up_palsel * 16 + (p.up_pixel ? p.up_ink : 8 + p.up_paper);
	return `PAL_UP_BASE + p.border[2:0];
endfunction

// called after the read, so the shadow stays read-first
function automatic void write_shadow(input int zx, input palette_pkg::pal_wr_t w);
	int         a;
	logic [7:0] d;
	if (w.src == palette_pkg::PAL_SRC_ATM)
	begin
		a      = zx;
		d[7:5] = {w.data[3:2], 1'b0}; // green
		d[4:2] = {w.data[5:4], 1'b0}; // red
		d[1:0] = w.data[1:0];         // blue
	end
	else
	begin
		a = `PAL_UP_BASE + w.addr;
		d = w.data;
	end
	shadow[a] = d;
	known[a]  = 1'b1;
endfunction

// 3 bits down to 2, odd values round up when plus1
function automatic logic [1:0] dither_ref(input logic [2:0] c, input logic plus1);
	logic [3:0] s;
	s = {1'b0, c} + (c[0] & plus1);
	return (c == 3'd7) ? 2'd3 : s[2:1];
endfunction

// reference colour for one position
function automatic expect_t expected_out(input video_pkg::raster_t r, input logic [7:0] ent,
		input bit kn, input logic plus1);
	expect_t    e;
	logic       blank;
	logic [2:0] g3;
	logic [2:0] r3;
	blank       = r.hblank | r.vblank;
	g3          = ent[7:5];
	r3          = ent[4:2];
	e.valid     = 1'b1;
	e.chk_color = kn | blank;
	e.chk_pal   = kn;
	e.vo.hsync  = r.hsync;
	e.vo.vsync  = r.vsync;
	e.vo.blank  = blank;
	e.vo.color  = blank ? 6'd0 : {dither_ref(g3, plus1), dither_ref(r3, plus1), ent[1:0]};
	e.pc        = {r3[2:1], g3[2:1], ent[1:0]}; // top bits of red and green, then blue
	return e;
endfunction

task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		$display("SIMULATION FAILED");
		$fatal(1, "mismatch on %s", name);
	end
endtask

`endif

//--- verification/tb_video_top.sv
/* testbench for video_top, random picture and palette writes
   compared with the reference model two clocks later */
`include "video_consts.svh"

module tb_video_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYC   = 8;
	localparam int FRAME       = `H_TOTAL * `V_TOTAL;
	localparam int N_POS       = 6 * FRAME;
	localparam int TIMEOUT_CYC = N_POS + RESET_CYC + 152; // 6 frames, reset, margin

	logic                 clk;
	logic                 reset;
	video_pkg::pix_in_t   pix_in;
	palette_pkg::pal_wr_t pal_wr;
	logic                 up_ena;
	video_pkg::vid_out_t  vid_out;
	logic [5:0]           palcolor;

	int                   cyc = 0;
	int                   tmo_cnt = 0;
	int                   h;
	int                   v;
	int                   k;       // position count since reset
	int                   idx;
	logic [1:0]           ctr;     // dither model
	logic                 line_f;
	logic                 frame_f;
	logic                 vs_r;
	video_pkg::raster_t   r;
	video_pkg::pix_in_t   pix;
	palette_pkg::pal_wr_t wr;
	logic                 up;

	`include "video_ref_model.svh"

	expect_t e;
	expect_t exp_line [3]; // oldest in slot 2

	video_top video_top_inst (
		.clk      (clk),
		.reset    (reset),
		.pix_in   (pix_in),
		.pal_wr   (pal_wr),
		.up_ena   (up_ena),
		.vid_out  (vid_out),
		.palcolor (palcolor)
	);

	initial
	begin
		clk      = 1'b0;
		reset    = 1'b1;
		pix_in   = '0;
		pal_wr   = '0;
		up_ena   = 1'b0;
		exp_line = '{default: '0};
		forever #5 clk = ~clk;
	end

	// stimulus for the position shown after this edge
	always @(posedge clk)
	begin
		if (cyc == RESET_CYC + N_POS + 2)
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
		begin
			if (reset) // old value, raster restarts
			begin
				h = 0;
				v = 0;
				{ctr, line_f, frame_f, vs_r} = '0;
			end
			else if (h == `H_TOTAL - 1)
			begin
				h = 0;
				v = (v == `V_TOTAL - 1) ? 0 : v + 1;
			end
			else
				h = h + 1;
			reset <= (cyc < RESET_CYC - 1);
			k   = cyc - (RESET_CYC - 1);
			pix = '0;
			wr  = '0;
			up  = 1'b0;
			e   = '0;
			if (k < 0) // reset output, also first cycle after
			begin
				{e.valid, e.chk_color, e.chk_pal} = 3'b111;
				e.vo.blank = 1'b1;
			end
			else if (k < N_POS)
			begin
				pix = 17'(rand_bits(17)); // every field of the picture input
				case (k / FRAME)
					0:
					begin
						if (k < 16) // steer both indices, fills classic entries
						begin
							pix.pixels = 4'(k);
							pix.border = 4'(k);
							wr.valid   = 1'b1;
						end
					end
					2:
					begin
						up = 1'b1;
						if (k - 2 * FRAME < 64) // all ulaplus entries in turn
						begin
							wr.valid = 1'b1;
							wr.src   = palette_pkg::PAL_SRC_ULAPLUS;
							wr.addr  = 6'(k - 2 * FRAME);
						end
					end
					4, 5: // mixed sources and modes
					begin
						up       = 1'(rand_bits(1));
						wr.valid = (rand_bits(2) == 0);
						wr.src   = palette_pkg::pal_src_e'(1'(rand_bits(1)));
						wr.addr  = 6'(rand_bits(6));
					end
					default: ; // frames 1 and 3 classic display only
				endcase
				wr.data = 8'(rand_bits(8));
				r       = raster_model(h, v);
				ctr     = ctr + 1'b1; // dither state after the sampling edge
				if (r.hsync_start)
					line_f = ~line_f;
				if (r.vsync && !vs_r)
					frame_f = ~frame_f;
				vs_r = r.vsync;
				idx  = read_index(r, pix, up);
				e    = expected_out(r, shadow[idx], known[idx], ctr[1] ^ line_f ^ frame_f);
				if (wr.valid)
					write_shadow(zx_index(r, pix), wr);
			end
			pix_in      <= pix;
			pal_wr      <= wr;
			up_ena      <= up;
			exp_line[2] = exp_line[1];
			exp_line[1] = exp_line[0];
			exp_line[0] = e;
			cyc++;
		end
	end

	// outputs settled by the falling edge
	always @(negedge clk)
	begin
		if (exp_line[2].valid)
		begin
			if (exp_line[2].chk_color)
				check_equal("vid_out", 32'(vid_out), 32'(exp_line[2].vo));
			else
				check_equal("vid_out sync/blank", 32'(vid_out[2:0]), 32'(exp_line[2].vo[2:0]));
			if (exp_line[2].chk_pal)
				check_equal("palcolor", 32'(palcolor), 32'(exp_line[2].pc));
		end
	end

	always @(posedge clk)
	begin
		tmo_cnt++;
		if (tmo_cnt >= TIMEOUT_CYC)
		begin
			$display("timeout, test did not reach its end after %0d cycles", tmo_cnt);
			$display("SIMULATION FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

endmodule

//--- video_palette.f
+incdir+common
+incdir+verification
common/video_pkg.sv
common/palette_pkg.sv
logic/raster_timing.sv
palframe/palette_ram.sv
palframe/color_dither.sv
palframe/palette_frame.sv
logic/video_top.sv
verification/tb_video_top.sv
